// ==== include/msu_settings.svh ====
`ifndef MSU_SETTINGS_SVH
`define MSU_SETTINGS_SVH

////////////////////////////////////////
// Streaming buffer geometry
////////////////////////////////////////

// 14 gives the full 16 KiB buffer, 12 and 13 also work
`define MSU_BUF_AW 14

// Flops in front of every edge detector
`define MSU_SYNC_STAGES 2

`endif

// ==== hw/msu_reg_pkg.sv ====
`default_nettype none

package msu_reg_pkg;

  // Host register map, same index for read and write
  typedef enum logic [2:0] {
    REG_STATUS_SEEK0 = 3'd0,  // Rd status / wr seek byte 0
    REG_DATA_SEEK1   = 3'd1,  // Rd data stream / wr seek byte 1
    REG_SEEK2        = 3'd2,
    REG_SEEK3        = 3'd3,  // Completes the seek request
    REG_TRACK0       = 3'd4,
    REG_TRACK1       = 3'd5,  // Completes the track request
    REG_VOLUME       = 3'd6,
    REG_CTRL         = 3'd7
  } msu_reg_e;

  // Status byte as the host reads it
  typedef struct packed {
    logic       data_busy;
    logic       audio_busy;
    logic [1:0] audio_status;
    logic       audio_error;
    logic [2:0] fixed;        // Always 3'b010
  } msu_status_t;

  // "S-MSU1", read back on registers 2 to 7
  parameter logic [7:0] msu_id [0:5] = '{8'h53, 8'h2D, 8'h4D, 8'h53, 8'h55, 8'h31};

endpackage

`default_nettype wire

// ==== hw/msu_buf_pkg.sv ====
`default_nettype none

`include "msu_settings.svh"

package msu_buf_pkg;

  // Byte address into the streaming buffer
  typedef logic [`MSU_BUF_AW-1:0] buf_addr_t;

  // One buffer byte
  typedef logic [7:0] buf_data_t;

endpackage

`default_nettype wire

// ==== hw/msu_host_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface msu_host_if;

  msu_reg_pkg::msu_reg_e reg_addr;   // Register index from the console
  logic [7:0]            wdata;      // Host write byte
  logic                  oe_fall;    // Read begins
  logic                  oe_rise;    // Read ends
  logic                  we_rise;    // Write ends, data is valid
  logic [7:0]            rdata;      // Registered read byte

  // Edge detector side
  modport src (output reg_addr, output wdata, output oe_fall, output oe_rise,
               output we_rise);

  // Register file side
  modport regs (input reg_addr, input wdata, input oe_fall, input we_rise,
                output rdata);

  // Pointer only watches the read strobes
  modport mon (input reg_addr, input oe_fall, input oe_rise);

endinterface

`default_nettype wire

// ==== hw/msu_bus_edges.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msu_settings.svh"

module msu_bus_edges (
  input  wire                   clkin,
  input  wire                   rst_n,
  input  wire                   enable,
  input  wire                   rd_n,
  input  wire                   wr_n,
  input  msu_reg_pkg::msu_reg_e reg_addr_in,
  input  wire [7:0]             wdata_in,
  msu_host_if.src               host
);

  localparam int SYNC = `MSU_SYNC_STAGES;

  logic [SYNC-1:0] rd_sync;
  logic [SYNC-1:0] wr_sync;
  logic            rd_prev;
  logic            wr_prev;
  logic            rd_s;
  logic            wr_s;

  assign rd_s = rd_sync[SYNC-1];  // Last synchronizer stage
  assign wr_s = wr_sync[SYNC-1];

  // Strobes come out registered, one cycle wide
  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      rd_sync      <= '1;  // Bus idles high
      wr_sync      <= '1;
      rd_prev      <= 1'b1;
      wr_prev      <= 1'b1;
      host.oe_fall <= 1'b0;
      host.oe_rise <= 1'b0;
      host.we_rise <= 1'b0;
    end else begin
      rd_sync      <= SYNC'({rd_sync, rd_n});
      wr_sync      <= SYNC'({wr_sync, wr_n});
      rd_prev      <= rd_s;
      wr_prev      <= wr_s;
      host.oe_fall <= enable & rd_prev & ~rd_s;
      host.oe_rise <= enable & ~rd_prev & rd_s;
      host.we_rise <= enable & ~wr_prev & wr_s;
    end
  end

  // Address and data are held by the host for the whole access
  assign host.reg_addr = reg_addr_in;
  assign host.wdata    = wdata_in;

endmodule

`default_nettype wire

// ==== hw/msu_ptr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msu_settings.svh"

module msu_ptr (
  input  wire                   clkin,
  input  wire                   rst_n,
  msu_host_if.mon               host,
  input  msu_buf_pkg::buf_addr_t ext_addr,
  input  wire                   ext_write,
  output msu_buf_pkg::buf_addr_t rd_addr
);

  localparam int SYNC = `MSU_SYNC_STAGES;
  localparam int SRW  = SYNC + 1;

  logic [SRW-1:0]         ext_sr;
  logic                   ext_rise;
  logic                   inc_arm;
  msu_buf_pkg::buf_addr_t ptr;

  // Controller reload strobe crosses in here
  assign ext_rise = ext_sr[SYNC-1] & ~ext_sr[SYNC];

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      ext_sr  <= '0;
      inc_arm <= 1'b0;
      ptr     <= '0;
    end else begin
      ext_sr <= SRW'({ext_sr, ext_write});
      if (host.oe_fall && host.reg_addr == msu_reg_pkg::REG_DATA_SEEK1) begin
        inc_arm <= 1'b1;  // Data register read in progress
      end else if (host.oe_rise) begin
        inc_arm <= 1'b0;
      end
      if (ext_rise) begin
        ptr <= ext_addr;  // Reload beats a step
      end else if (host.oe_rise && inc_arm) begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  assign rd_addr = ptr;

endmodule

`default_nettype wire

// ==== hw/msu_databuf.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_databuf (
  input  wire                    clkin,
  input  wire                    wr_en_n,
  input  msu_buf_pkg::buf_addr_t wr_addr,
  input  msu_buf_pkg::buf_data_t wr_data,
  input  msu_buf_pkg::buf_addr_t rd_addr,
  output msu_buf_pkg::buf_data_t rd_data
);

  localparam int DEPTH = 2 ** $bits(msu_buf_pkg::buf_addr_t);

  msu_buf_pkg::buf_data_t mem [DEPTH];

  // Controller side
  always_ff @(posedge clkin) begin
    if (!wr_en_n) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Host side, one cycle latency
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== hw/msu_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msu_settings.svh"

module msu_regs (
  input  wire                    clkin,
  input  wire                    rst_n,
  msu_host_if.regs               host,
  input  msu_buf_pkg::buf_data_t buf_data,
  input  wire                    ptr_msb,
  input  wire [5:0]              status_reset_bits,
  input  wire [5:0]              status_set_bits,
  input  wire                    status_reset_we,
  output logic [7:0]             status_out,
  output logic [7:0]             volume_out,
  output logic                   volume_latch_out,
  output logic [31:0]            addr_out,
  output logic [15:0]            track_out
);

  localparam int SYNC = `MSU_SYNC_STAGES;
  localparam int SRW  = SYNC + 1;

  logic [SRW-1:0]           srst_sr;
  logic                     srst_en;
  logic                     data_busy;
  logic                     audio_busy;
  logic [1:0]               audio_status;
  logic                     audio_error;
  logic                     data_start;
  logic                     audio_start;
  logic                     ctrl_start;
  logic                     volume_latch;
  logic [2:0]               audio_ctrl;
  logic [2:0]               id_idx;
  msu_reg_pkg::msu_status_t status_byte;

  ////////////////////////////////////////
  // Host read path
  ////////////////////////////////////////

  assign status_byte.data_busy    = data_busy;
  assign status_byte.audio_busy   = audio_busy;
  assign status_byte.audio_status = audio_status;
  assign status_byte.audio_error  = audio_error;
  assign status_byte.fixed        = 3'b010;

  assign id_idx = host.reg_addr - 3'd2;  // ID starts at register 2

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      host.rdata <= '0;
    end else if (host.oe_fall) begin
      case (host.reg_addr)
        msu_reg_pkg::REG_STATUS_SEEK0: host.rdata <= status_byte;
        msu_reg_pkg::REG_DATA_SEEK1:   host.rdata <= buf_data;
        default:                       host.rdata <= msu_reg_pkg::msu_id[id_idx];
      endcase
    end
  end

  ////////////////////////////////////////
  // Host writes and status set/reset
  ////////////////////////////////////////

  assign srst_en = srst_sr[SYNC-1] & ~srst_sr[SYNC];

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      srst_sr      <= '0;
      data_busy    <= 1'b1;
      audio_busy   <= 1'b1;
      audio_status <= 2'b00;
      audio_error  <= 1'b0;
      data_start   <= 1'b0;
      audio_start  <= 1'b0;
      ctrl_start   <= 1'b0;
      volume_latch <= 1'b0;
      audio_ctrl   <= 3'b000;
      addr_out     <= '0;
      track_out    <= '0;
      volume_out   <= '0;
    end else begin
      srst_sr      <= SRW'({srst_sr, status_reset_we});
      volume_latch <= 1'b0;  // Single cycle unless rewritten
      if (host.we_rise) begin
        case (host.reg_addr)
          msu_reg_pkg::REG_STATUS_SEEK0: addr_out[7:0]   <= host.wdata;
          msu_reg_pkg::REG_DATA_SEEK1:   addr_out[15:8]  <= host.wdata;
          msu_reg_pkg::REG_SEEK2:        addr_out[23:16] <= host.wdata;
          msu_reg_pkg::REG_SEEK3: begin
            addr_out[31:24] <= host.wdata;
            data_start      <= 1'b1;
            data_busy       <= 1'b1;
          end
          msu_reg_pkg::REG_TRACK0:       track_out[7:0]  <= host.wdata;
          msu_reg_pkg::REG_TRACK1: begin
            track_out[15:8] <= host.wdata;
            audio_start     <= 1'b1;
            audio_busy      <= 1'b1;
          end
          msu_reg_pkg::REG_VOLUME: begin
            volume_out   <= host.wdata;
            volume_latch <= 1'b1;
          end
          default: begin
            // Control is locked while audio is busy
            if (!audio_busy) begin
              audio_ctrl <= host.wdata[2:0];
              ctrl_start <= 1'b1;
            end
          end
        endcase
      end else if (srst_en) begin
        audio_busy   <= (audio_busy | status_set_bits[5]) & ~status_reset_bits[5];
        data_busy    <= (data_busy | status_set_bits[4]) & ~status_reset_bits[4];
        audio_error  <= (audio_error | status_set_bits[3]) & ~status_reset_bits[3];
        audio_status <= (audio_status | status_set_bits[2:1]) & ~status_reset_bits[2:1];
        ctrl_start   <= (ctrl_start | status_set_bits[0]) & ~status_reset_bits[0];
        if (status_reset_bits[5]) begin
          audio_start <= 1'b0;  // Controller took the track
        end
        if (status_reset_bits[4]) begin
          data_start <= 1'b0;
        end
      end
    end
  end

  assign volume_latch_out = volume_latch;

  // Controller view of the requests
  assign status_out = {ptr_msb, audio_start, data_start, volume_latch, audio_ctrl, ctrl_start};

endmodule

`default_nettype wire

// ==== hw/msu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msu_settings.svh"

module msu_top (
  input  wire                    clkin,
  input  wire                    rst_n,
  input  wire                    enable,
  input  wire                    rd_n,
  input  wire                    wr_n,
  input  wire [2:0]              reg_addr,
  input  wire [7:0]              reg_data_in,
  output logic [7:0]             reg_data_out,
  input  msu_buf_pkg::buf_addr_t pgm_address,
  input  msu_buf_pkg::buf_data_t pgm_data,
  input  wire                    pgm_we,          // Active low
  input  msu_buf_pkg::buf_addr_t msu_address_ext,
  input  wire                    msu_address_ext_write,
  input  wire [5:0]              status_reset_bits,
  input  wire [5:0]              status_set_bits,
  input  wire                    status_reset_we,
  output logic [7:0]             status_out,
  output logic [7:0]             volume_out,
  output logic                   volume_latch_out,
  output logic [31:0]            addr_out,
  output logic [15:0]            track_out
);

  msu_buf_pkg::buf_addr_t buf_rd_addr;
  msu_buf_pkg::buf_data_t buf_rd_data;

  msu_host_if hif ();

  msu_bus_edges u_edges (
    .clkin       (clkin),
    .rst_n       (rst_n),
    .enable      (enable),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .reg_addr_in (msu_reg_pkg::msu_reg_e'(reg_addr)),
    .wdata_in    (reg_data_in),
    .host        (hif.src)
  );

  msu_ptr u_ptr (
    .clkin     (clkin),
    .rst_n     (rst_n),
    .host      (hif.mon),
    .ext_addr  (msu_address_ext),
    .ext_write (msu_address_ext_write),
    .rd_addr   (buf_rd_addr)
  );

  msu_databuf u_buf (
    .clkin   (clkin),
    .wr_en_n (pgm_we),
    .wr_addr (pgm_address),
    .wr_data (pgm_data),
    .rd_addr (buf_rd_addr),
    .rd_data (buf_rd_data)
  );

  msu_regs u_regs (
    .clkin             (clkin),
    .rst_n             (rst_n),
    .host              (hif.regs),
    .buf_data          (buf_rd_data),
    .ptr_msb           (buf_rd_addr[`MSU_BUF_AW-1]),  // Buffer half in use
    .status_reset_bits (status_reset_bits),
    .status_set_bits   (status_set_bits),
    .status_reset_we   (status_reset_we),
    .status_out        (status_out),
    .volume_out        (volume_out),
    .volume_latch_out  (volume_latch_out),
    .addr_out          (addr_out),
    .track_out         (track_out)
  );

  assign reg_data_out = hif.rdata;

endmodule

`default_nettype wire

// ==== bench/msu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_chk (
  input wire       clkin,
  input wire       rst_n,
  input wire [7:0] status_out,
  input wire       volume_latch_out,
  input wire       audio_busy
);

  int unsigned fail_count = 0;  // Polled by the testbench

  // Latch is a one cycle pulse
  latch_single: assert property (@(posedge clkin) disable iff (!rst_n)
    volume_latch_out |=> !volume_latch_out)
    else begin
      fail_count++;
      $error("volume_latch_out stayed high for two cycles");
    end

  // Start flags held clear in reset
  starts_in_reset: assert property (@(posedge clkin)
    !rst_n |-> (status_out[6:5] == 2'b00) && !status_out[0])
    else begin
      fail_count++;
      $error("start flag set while rst_n is low");
    end

  // Control field locked while audio busy
  ctrl_locked: assert property (@(posedge clkin) disable iff (!rst_n)
    audio_busy |=> $stable(status_out[3:1]))
    else begin
      fail_count++;
      $error("control field changed while audio_busy is set");
    end

endmodule

`default_nettype wire

// ==== bench/msu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_tb;

  localparam int CLK_PERIOD = 100;
  localparam int CYC_PER_OP = 20;   // Longest operation is about 10 cycles
  localparam int WD_MARGIN  = 200;

  logic                   clkin = 1'b0;
  logic                   rst_n;
  logic                   enable;
  logic                   rd_n;
  logic                   wr_n;
  logic [2:0]             reg_addr;
  logic [7:0]             reg_data_in;
  logic [7:0]             reg_data_out;
  msu_buf_pkg::buf_addr_t pgm_address;
  msu_buf_pkg::buf_data_t pgm_data;
  logic                   pgm_we;
  msu_buf_pkg::buf_addr_t msu_address_ext;
  logic                   msu_address_ext_write;
  logic [5:0]             status_reset_bits;
  logic [5:0]             status_set_bits;
  logic                   status_reset_we;
  logic [7:0]             status_out;
  logic [7:0]             volume_out;
  logic                   volume_latch_out;
  logic [31:0]            addr_out;
  logic [15:0]            track_out;

  logic [7:0]  op_q[$];
  logic [31:0] arg_a_q[$];
  logic [31:0] arg_b_q[$];
  int          trace_len = 0;
  int          latch_cycles = 0;   // Latch pulses seen during the last write
  int          pulse_cycles = 0;   // Same pulse on volume_latch_out

  msu_top dut (.*);

  bind msu_top msu_chk chk (
    .clkin            (clkin),
    .rst_n            (rst_n),
    .status_out       (status_out),
    .volume_latch_out (volume_latch_out),
    .audio_busy       (u_regs.audio_busy)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clkin = ~clkin;
  end

  ////////////////////////////////////////
  // Failure handling and compare
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic load_trace();
    int          fd;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("bench/msu_trace.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open bench/msu_trace.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin  // Skip comments and blanks
        if ($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b) != 2) begin
          abort_run($sformatf("Trace line could not be parsed: %s", line));
        end
        op_q.push_back(line.getc(0));
        arg_a_q.push_back(a);
        arg_b_q.push_back(b);
      end
    end
    $fclose(fd);
    if (op_q.size() == 0) begin
      abort_run("Trace file holds no operations");
    end
    trace_len = op_q.size();
  endtask

  ////////////////////////////////////////
  // Bus and controller operations
  ////////////////////////////////////////

  task automatic host_write(input logic [2:0] addr, input logic [7:0] data);
    reg_addr    = addr;
    reg_data_in = data;
    wr_n        = 1'b0;
    repeat (6) @(negedge clkin);
    wr_n         = 1'b1;
    latch_cycles = 0;
    pulse_cycles = 0;
    repeat (4) begin
      @(negedge clkin);
      if (status_out[4]) latch_cycles++;  // Latch shows up about 4 cycles in
      if (volume_latch_out) pulse_cycles++;
    end
  endtask

  task automatic host_read(input logic [2:0] addr, input logic [7:0] exp);
    reg_addr = addr;
    rd_n     = 1'b0;
    repeat (6) @(negedge clkin);
    check_value($sformatf("reg_data_out (reg %0d)", addr), 32'(reg_data_out), 32'(exp));
    rd_n = 1'b1;
    repeat (4) @(negedge clkin);
  endtask

  task automatic program_byte(input logic [31:0] addr, input logic [7:0] data);
    pgm_address = msu_buf_pkg::buf_addr_t'(addr);
    pgm_data    = data;
    pgm_we      = 1'b0;
    @(negedge clkin);
    pgm_we = 1'b1;
  endtask

  task automatic reload_pointer(input logic [31:0] addr);
    msu_address_ext       = msu_buf_pkg::buf_addr_t'(addr);
    msu_address_ext_write = 1'b1;
    repeat (4) @(negedge clkin);
    msu_address_ext_write = 1'b0;
    repeat (2) @(negedge clkin);
  endtask

  task automatic status_update(input logic [5:0] set_bits, input logic [5:0] clr_bits);
    status_set_bits   = set_bits;
    status_reset_bits = clr_bits;
    status_reset_we   = 1'b1;
    repeat (4) @(negedge clkin);
    status_reset_we = 1'b0;
    repeat (4) @(negedge clkin);
    status_set_bits   = '0;
    status_reset_bits = '0;
  endtask

  task automatic check_output(input logic [31:0] sel, input logic [31:0] exp);
    case (sel)
      0: check_value("addr_out", addr_out, exp);
      1: check_value("track_out", 32'(track_out), exp);
      2: check_value("volume_out", 32'(volume_out), exp);
      3: check_value("status_out", 32'(status_out), exp);
      4: begin
        check_value("volume latch cycles", 32'(latch_cycles), exp);
        check_value("volume_latch_out cycles", 32'(pulse_cycles), exp);
      end
      default: abort_run($sformatf("Unknown output selector %0d in trace", sel));
    endcase
  endtask

  task automatic run_op(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b);
    case (op)
      "P": program_byte(a, b[7:0]);
      "L": reload_pointer(a);
      "W": host_write(a[2:0], b[7:0]);
      "R": host_read(a[2:0], b[7:0]);
      "S": status_update(a[5:0], b[5:0]);
      "C": check_output(a, b);
      "E": begin
        enable = a[0];
        @(negedge clkin);
      end
      default: abort_run($sformatf("Unknown trace operation %c", op));
    endcase
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n                 = 1'b0;
    enable                = 1'b1;
    rd_n                  = 1'b1;
    wr_n                  = 1'b1;
    reg_addr              = '0;
    reg_data_in           = '0;
    pgm_address           = '0;
    pgm_data              = '0;
    pgm_we                = 1'b1;
    msu_address_ext       = '0;
    msu_address_ext_write = 1'b0;
    status_reset_bits     = '0;
    status_set_bits       = '0;
    status_reset_we       = 1'b0;
    load_trace();
    repeat (2) @(negedge clkin);
    rst_n = 1'b1;
    repeat (2) @(negedge clkin);
    foreach (op_q[i]) begin
      run_op(op_q[i], arg_a_q[i], arg_b_q[i]);
    end
    if (dut.chk.fail_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "Assertion failures in the checker");
    end
  end

  // Catches checker failures as they happen
  always @(negedge clkin) begin
    if (dut.chk.fail_count != 0) begin
      abort_run("A concurrent assertion in the checker failed");
    end
  end

  // Watchdog sized from the trace
  initial begin
    wait (trace_len > 0);
    repeat (trace_len * CYC_PER_OP + WD_MARGIN) @(posedge clkin);
    abort_run("Timeout, the trace did not complete in the allowed cycles");
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
hw/msu_reg_pkg.sv
hw/msu_buf_pkg.sv
hw/msu_host_if.sv
hw/msu_bus_edges.sv
hw/msu_ptr.sv
hw/msu_databuf.sv
hw/msu_regs.sv
hw/msu_top.sv
bench/msu_chk.sv
bench/msu_tb.sv

// ==== Makefile ====
# Verilator flow for the MSU register block

VERILATOR ?= verilator
TOP       ?= msu_tb
RTL_TOP   ?= msu_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/msu_trace.txt ====
# Columns: op a b, numbers in hex
# P buf[a]=b, L pointer=a, W reg a<=b, R reg a expect b, S set a reset b, E enable=a
# C output a (0 addr, 1 track, 2 volume, 3 status_out, 4 latch cycles) expect b
R 0 C2
R 2 53
R 3 2D
R 4 4D
R 5 53
R 6 55
R 7 31
C 3 0
W 0 78
W 1 56
W 2 34
W 3 12
C 0 12345678
C 3 20
S 0 10
C 3 0
R 0 42
P 100 A1
P 101 B2
P 102 C3
L 100 0
R 1 A1
R 1 B2
R 0 42
R 1 C3
W 4 34
W 5 12
C 4 0
C 1 1234
C 3 40
W 6 9C
C 4 1
C 2 9C
W 7 5
C 3 40
S 0 20
C 3 0
R 0 2
W 7 5
C 3 B
S 8 1
C 3 A
R 0 A
E 0 0
W 7 2
W 6 11
C 3 A
C 2 9C
C 4 0
R 2 A
E 1 0
R 2 53
